//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert --top-module lcdControllerTb \
		-f filelist.f -Mdir obj_dir
	./obj_dir/VlcdControllerTb | tee $(LOG)
	grep -q "Simulation completed successfully" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

//--- filelist.f
hdl/lcdTimingPkg.sv
hdl/lcdCommandPkg.sv
hdl/lcdNibbleWriter.sv
hdl/lcdInitSequencer.sv
hdl/lcdController.sv
tests/lcdControllerTb.sv

//--- hdl/lcdCommandPkg.sv
package lcdCommandPkg;

	////////////////////////////////////////
	// Bus payload and wait classes
	////////////////////////////////////////

	typedef logic [3:0] nibbleT; // DB7..DB4 of the display

	// Which wait follows a nibble, mapped to cycles by the sequencer
	typedef enum logic [2:0]
	{
		gapInit1, // After first 0x3
		gapInit2, // After second 0x3
		gapInit3, // After third 0x3 and the 0x2
		gapShort, // Between upper and lower half
		gapLong, // After lower half
		gapClear // After clear display
	} gapClassT;

	// One nibble write and the wait behind it
	typedef struct packed
	{
		nibbleT nibble; // Value on the bus
		gapClassT gap; // Wait class after the write
	} stepT;

	////////////////////////////////////////
	// Initialisation table
	////////////////////////////////////////

	localparam int StepCount = 12; // Nibble writes in total

	// Wake-up nibbles, then 0x28, 0x06, 0x0C, 0x01 as upper/lower halves
	localparam stepT InitSteps [0:StepCount-1] = '{
		'{nibble: 4'h3, gap: gapInit1}, // Wake-up 1
		'{nibble: 4'h3, gap: gapInit2}, // Wake-up 2
		'{nibble: 4'h3, gap: gapInit3}, // Wake-up 3
		'{nibble: 4'h2, gap: gapInit3}, // Switch to 4-bit mode
		'{nibble: 4'h2, gap: gapShort}, // Function set, upper
		'{nibble: 4'h8, gap: gapLong}, // Function set, lower
		'{nibble: 4'h0, gap: gapShort}, // Entry mode, upper
		'{nibble: 4'h6, gap: gapLong}, // Entry mode, lower
		'{nibble: 4'h0, gap: gapShort}, // Display on, upper
		'{nibble: 4'hC, gap: gapLong}, // Display on, lower
		'{nibble: 4'h0, gap: gapShort}, // Clear, upper
		'{nibble: 4'h1, gap: gapClear} // Clear, lower
	};

endpackage

//--- hdl/lcdController.sv
`timescale 1ns/1ps

module lcdController
#(
	parameter int PowerOnCycles = lcdTimingPkg::PowerOnCycles,
	parameter int Init1Cycles = lcdTimingPkg::Init1Cycles,
	parameter int Init2Cycles = lcdTimingPkg::Init2Cycles,
	parameter int Init3Cycles = lcdTimingPkg::Init3Cycles,
	parameter int ShortGapCycles = lcdTimingPkg::ShortGapCycles,
	parameter int LongGapCycles = lcdTimingPkg::LongGapCycles,
	parameter int ClearGapCycles = lcdTimingPkg::ClearGapCycles,
	parameter int EnableCycles = lcdTimingPkg::EnableCycles
)
(
	input logic Clock,
	input logic rst,
	output logic LcdEnable, // E line
	output lcdCommandPkg::nibbleT LcdData, // DB7..DB4
	output logic Ready // Init sequence complete
);

	////////////////////////////////////////
	// Sequencer to writer
	////////////////////////////////////////

	logic writeStart;
	lcdCommandPkg::nibbleT writeNibble;
	lcdTimingPkg::countT writeGap;
	logic writeDone;

	lcdInitSequencer #(
		.PowerOnCycles(PowerOnCycles),
		.Init1Cycles(Init1Cycles),
		.Init2Cycles(Init2Cycles),
		.Init3Cycles(Init3Cycles),
		.ShortGapCycles(ShortGapCycles),
		.LongGapCycles(LongGapCycles),
		.ClearGapCycles(ClearGapCycles)
	) u_lcdInitSequencer (
		.Clock(Clock),
		.rst(rst),
		.WriteDone(writeDone),
		.WriteStart(writeStart),
		.WriteNibble(writeNibble),
		.WriteGap(writeGap),
		.Ready(Ready)
	);

	lcdNibbleWriter #(
		.EnableCycles(EnableCycles)
	) u_lcdNibbleWriter (
		.Clock(Clock),
		.rst(rst),
		.WriteStart(writeStart),
		.WriteNibble(writeNibble),
		.WriteGap(writeGap),
		.WriteDone(writeDone),
		.LcdEnable(LcdEnable),
		.LcdData(LcdData)
	);

endmodule

//--- hdl/lcdInitSequencer.sv
`timescale 1ns/1ps

module lcdInitSequencer
#(
	parameter int PowerOnCycles = 750000,
	parameter int Init1Cycles = 205000,
	parameter int Init2Cycles = 5000,
	parameter int Init3Cycles = 2000,
	parameter int ShortGapCycles = 60,
	parameter int LongGapCycles = 2050,
	parameter int ClearGapCycles = 82500
)
(
	input logic Clock,
	input logic rst,
	input logic WriteDone, // From the nibble writer
	output logic WriteStart, // One-cycle request to the writer
	output lcdCommandPkg::nibbleT WriteNibble, // Nibble of the current step
	output lcdTimingPkg::countT WriteGap, // Wait after the current step
	output logic Ready // Display configured
);

	////////////////////////////////////////
	// Types and state
	////////////////////////////////////////

	localparam int IdxWidth = $clog2(lcdCommandPkg::StepCount + 1); // Holds 0..StepCount

	typedef logic [IdxWidth-1:0] idxT;

	localparam idxT LastStep = idxT'(lcdCommandPkg::StepCount - 1);

	typedef enum logic [1:0]
	{
		phasePowerOn, // Waiting for the display to settle
		phaseStep, // Walking through the table
		phaseReady // Done, idle until reset
	} phaseT;

	phaseT phase;
	lcdTimingPkg::countT powerCnt; // Counts up through the power-on wait
	idxT stepIdx; // Step being written, StepCount once finished
	lcdCommandPkg::stepT curStep; // Table entry at stepIdx

	////////////////////////////////////////
	// Phase control
	////////////////////////////////////////

	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			phase <= phasePowerOn;
			powerCnt <= '0;
			stepIdx <= '0;
			WriteStart <= 1'b0;
			Ready <= 1'b0;
		end
		else
		begin
			WriteStart <= 1'b0; // Pulse by default
			case (phase)
				phasePowerOn:
				begin
					if (powerCnt == lcdTimingPkg::countT'(PowerOnCycles))
					begin
						WriteStart <= 1'b1; // Kick off step 1
						phase <= phaseStep;
					end
					else
						powerCnt <= powerCnt + lcdTimingPkg::countT'(1);
				end
				phaseStep:
				begin
					if (WriteDone)
					begin
						stepIdx <= stepIdx + idxT'(1);
						if (stepIdx == LastStep)
							phase <= phaseReady; // Clear display finished
						else
							WriteStart <= 1'b1; // Next step right behind WriteDone
					end
				end
				phaseReady:
					Ready <= 1'b1; // Held until reset
				default:
					phase <= phasePowerOn;
			endcase
		end
	end

	////////////////////////////////////////
	// Table lookup
	////////////////////////////////////////

	always_comb
	begin
		curStep = '0; // Past the end, bus payload is don't-care
		if (stepIdx < idxT'(lcdCommandPkg::StepCount))
			curStep = lcdCommandPkg::InitSteps[stepIdx];
	end

	assign WriteNibble = curStep.nibble;

	// Wait class to cycle count
	always_comb
	begin
		case (curStep.gap)
			lcdCommandPkg::gapInit1: WriteGap = lcdTimingPkg::countT'(Init1Cycles);
			lcdCommandPkg::gapInit2: WriteGap = lcdTimingPkg::countT'(Init2Cycles);
			lcdCommandPkg::gapInit3: WriteGap = lcdTimingPkg::countT'(Init3Cycles);
			lcdCommandPkg::gapShort: WriteGap = lcdTimingPkg::countT'(ShortGapCycles);
			lcdCommandPkg::gapLong: WriteGap = lcdTimingPkg::countT'(LongGapCycles);
			lcdCommandPkg::gapClear: WriteGap = lcdTimingPkg::countT'(ClearGapCycles);
			default: WriteGap = lcdTimingPkg::countT'(LongGapCycles); // Unused encodings
		endcase
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	assert property (@(posedge Clock) disable iff (rst)
		stepIdx <= idxT'(lcdCommandPkg::StepCount))
	else
		$error("lcdInitSequencer: step index %0d out of range", stepIdx);

	// No bus traffic once configured
	assert property (@(posedge Clock) disable iff (rst)
		(phase == phaseReady) |-> !WriteStart)
	else
		$error("lcdInitSequencer: WriteStart in ready phase");

endmodule

//--- hdl/lcdNibbleWriter.sv
`timescale 1ns/1ps

module lcdNibbleWriter
#(
	parameter int EnableCycles = 12 // Enable high time in cycles
)
(
	input logic Clock,
	input logic rst,
	input logic WriteStart, // Single-cycle request
	input lcdCommandPkg::nibbleT WriteNibble, // Value to put on the bus
	input lcdTimingPkg::countT WriteGap, // Idle cycles after enable falls
	output logic WriteDone, // Last gap cycle
	output logic LcdEnable, // E line of the display
	output lcdCommandPkg::nibbleT LcdData // DB7..DB4
);

	////////////////////////////////////////
	// State
	////////////////////////////////////////

	logic busy; // Write in flight, enable or gap phase
	lcdTimingPkg::countT cnt; // Cycles left in the current phase
	lcdTimingPkg::countT gapReg; // Gap length captured at start

	////////////////////////////////////////
	// Enable pulse and gap sequencing
	////////////////////////////////////////

	// LcdEnable doubles as the phase flag, high means enable phase
	always_ff @(posedge Clock)
	begin
		if (rst)
		begin
			busy <= 1'b0;
			LcdEnable <= 1'b0;
			LcdData <= '0; // Data lines low out of reset
			cnt <= '0;
		end
		else if (!busy)
		begin
			if (WriteStart)
			begin
				busy <= 1'b1;
				LcdEnable <= 1'b1; // High from the next cycle on
				LcdData <= WriteNibble; // Held until the next write
				gapReg <= WriteGap;
				cnt <= lcdTimingPkg::countT'(EnableCycles - 1);
			end
		end
		else if (cnt != '0)
			cnt <= cnt - lcdTimingPkg::countT'(1); // Still inside a phase
		else if (LcdEnable)
		begin
			LcdEnable <= 1'b0; // Falling edge latches the nibble
			cnt <= gapReg - lcdTimingPkg::countT'(1);
		end
		else
			busy <= 1'b0; // Gap over, WriteDone seen this cycle
	end

	// Decoded from registers, one cycle wide
	assign WriteDone = busy && !LcdEnable && (cnt == '0);

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Sequencer must wait for WriteDone before the next request
	assert property (@(posedge Clock) disable iff (rst)
		WriteStart |-> !busy)
	else
		$error("lcdNibbleWriter: WriteStart while a write is in flight");

	// Pulse width bounded by the parameter
	assert property (@(posedge Clock) disable iff (rst)
		$rose(LcdEnable) |-> ##EnableCycles !LcdEnable)
	else
		$error("lcdNibbleWriter: LcdEnable held longer than %0d cycles", EnableCycles);

endmodule

//--- hdl/lcdTimingPkg.sv
package lcdTimingPkg;

	////////////////////////////////////////
	// Clock reference
	////////////////////////////////////////

	localparam int ClockMHz = 50; // Board oscillator

	////////////////////////////////////////
	// LCD waits in clock cycles
	////////////////////////////////////////

	// Power-on settle time of the display controller
	localparam int PowerOnCycles = 15000 * ClockMHz; // 15 ms

	// Waits after the wake-up nibbles 0x3, 0x3, 0x3
	localparam int Init1Cycles = 4100 * ClockMHz; // 4.1 ms
	localparam int Init2Cycles = 100 * ClockMHz; // 100 us
	localparam int Init3Cycles = 40 * ClockMHz; // 40 us, also after 0x2

	// Gap between upper and lower half of a command
	localparam int ShortGapCycles = (6 * ClockMHz) / 5; // 1.2 us

	// Gap after the lower half of an ordinary command
	localparam int LongGapCycles = 41 * ClockMHz; // 41 us

	// Clear display needs far more than the others
	localparam int ClearGapCycles = 1650 * ClockMHz; // 1.65 ms

	// Enable high time, the bus latches on its falling edge
	localparam int EnableCycles = (24 * ClockMHz) / 100; // 240 ns

	////////////////////////////////////////
	// Counter sizing
	////////////////////////////////////////

	// Power-on wait is the longest count in the design
	localparam int CountWidth = $clog2(PowerOnCycles + 1); // 20 bits at 50 MHz

	typedef logic [CountWidth-1:0] countT; // Shared wait counter

endpackage

//--- tests/lcdControllerTb.sv
`timescale 1ns/1ps

module lcdControllerTb;

	////////////////////////////////////////
	// Shortened waits
	////////////////////////////////////////

	localparam int PowerOnCycles = 40;
	localparam int Init1Cycles = 30;
	localparam int Init2Cycles = 20;
	localparam int Init3Cycles = 10;
	localparam int ShortGapCycles = 3;
	localparam int LongGapCycles = 8;
	localparam int ClearGapCycles = 25;
	localparam int EnableCycles = 4;

	localparam int StepTotal = 12; // Nibble writes per init run
	localparam int ResetCycles = 3; // First reset length
	localparam int ReadyTimeout = 400; // Release to Ready, with margin
	localparam int IdleCycles = 60; // Quiet window after Ready
	localparam int MidSpan = 190; // Spread of reset points over the writes
	localparam int ResetRounds = 3; // Mid-sequence resets back to back
	localparam int MaxCycles = 3000; // Hard stop for the run

	// Bus values in the order the display must see them
	localparam logic [3:0] ExpNibbles [0:StepTotal-1] = '{
		4'h3, 4'h3, 4'h3, 4'h2, // Wake-up, then 4-bit mode
		4'h2, 4'h8, // Function set
		4'h0, 4'h6, // Entry mode
		4'h0, 4'hC, // Display on
		4'h0, 4'h1 // Clear
	};

	// Wait behind each write
	localparam int ExpGaps [0:StepTotal-1] = '{
		Init1Cycles, Init2Cycles, Init3Cycles, Init3Cycles,
		ShortGapCycles, LongGapCycles, ShortGapCycles, LongGapCycles,
		ShortGapCycles, LongGapCycles, ShortGapCycles, ClearGapCycles
	};

	////////////////////////////////////////
	// DUT and clock
	////////////////////////////////////////

	logic Clock;
	logic rst;
	logic LcdEnable;
	lcdCommandPkg::nibbleT LcdData;
	logic Ready;

	lcdController #(
		.PowerOnCycles(PowerOnCycles),
		.Init1Cycles(Init1Cycles),
		.Init2Cycles(Init2Cycles),
		.Init3Cycles(Init3Cycles),
		.ShortGapCycles(ShortGapCycles),
		.LongGapCycles(LongGapCycles),
		.ClearGapCycles(ClearGapCycles),
		.EnableCycles(EnableCycles)
	) u_lcdController (
		.Clock(Clock),
		.rst(rst),
		.LcdEnable(LcdEnable),
		.LcdData(LcdData),
		.Ready(Ready)
	);

	initial
	begin
		Clock = 1'b0;
		forever
			#20 Clock = ~Clock; // 40 ns period
	end

	////////////////////////////////////////
	// Bus history
	////////////////////////////////////////

	int valueErrors = 0;
	int timingErrors = 0;
	int timeoutErrors = 0;

	int riseIdx = 0; // Enable rises since last reset
	int sinceRelease = 0; // Cycles since rst went low
	int sinceRise = 0; // Cycles since latest rise
	logic prevEnable = 1'b0;
	logic prevReady = 1'b0;
	logic prevRst = 1'b0;
	lcdCommandPkg::nibbleT prevData = '0;
	logic rise;
	int unsigned lcgState; // Random state, seeded in the stimulus

	assign rise = LcdEnable && !prevEnable; // Enable went high this cycle

	always @(posedge Clock)
	begin
		prevRst <= rst;
		if (rst)
		begin
			riseIdx <= 0;
			sinceRelease <= 0;
			sinceRise <= 0;
			prevEnable <= 1'b0;
			prevReady <= 1'b0;
			prevData <= '0;
		end
		else
		begin
			sinceRelease <= sinceRelease + 1;
			sinceRise <= rise ? 1 : sinceRise + 1; // Restart at every rise
			if (rise)
				riseIdx <= riseIdx + 1;
			prevEnable <= LcdEnable;
			prevReady <= Ready;
			prevData <= LcdData;
		end
	end

	////////////////////////////////////////
	// Checks
	////////////////////////////////////////

	// Quiet bus during power-on wait
	assert property (@(posedge Clock) disable iff (rst)
		(riseIdx == 0 && sinceRelease < PowerOnCycles + 2) |-> (!LcdEnable && !Ready))
	else
	begin
		timingErrors++;
		$display("Error: LcdEnable = %h, Ready = %h before the first write",
			$sampled(LcdEnable), $sampled(Ready));
	end

	assert property (@(posedge Clock) disable iff (rst)
		(rise && riseIdx == 0) |-> (sinceRelease == PowerOnCycles + 2))
	else
	begin
		timingErrors++;
		$display("Error: first LcdEnable rise after %h cycles, expected %h",
			$sampled(sinceRelease), PowerOnCycles + 2);
	end

	// Nibble order
	assert property (@(posedge Clock) disable iff (rst)
		(rise && riseIdx < StepTotal) |-> (LcdData == ExpNibbles[riseIdx]))
	else
	begin
		valueErrors++;
		$display("Error: LcdData = %h, expected %h at write %0d",
			$sampled(LcdData), ExpNibbles[$sampled(riseIdx)], $sampled(riseIdx) + 1);
	end

	assert property (@(posedge Clock) disable iff (rst)
		rise |-> (riseIdx < StepTotal))
	else
	begin
		timingErrors++;
		$display("An LcdEnable pulse came after the last initialisation write");
	end

	// Pulse width, both ends
	assert property (@(posedge Clock) disable iff (rst)
		(LcdEnable && prevEnable) |-> (sinceRise < EnableCycles))
	else
	begin
		timingErrors++;
		$display("Error: LcdEnable high for %h cycles, limit %h",
			$sampled(sinceRise) + 1, EnableCycles);
	end

	assert property (@(posedge Clock) disable iff (rst)
		(!LcdEnable && prevEnable) |-> (sinceRise == EnableCycles))
	else
	begin
		timingErrors++;
		$display("Error: LcdEnable pulse of %h cycles, expected %h",
			$sampled(sinceRise), EnableCycles);
	end

	// Data held while enable is high
	assert property (@(posedge Clock) disable iff (rst)
		(LcdEnable && prevEnable) |-> (LcdData == prevData))
	else
	begin
		valueErrors++;
		$display("Error: LcdData = %h changed from %h during enable",
			$sampled(LcdData), $sampled(prevData));
	end

	// Rise spacing from the wait of the previous step
	assert property (@(posedge Clock) disable iff (rst)
		(rise && riseIdx > 0 && riseIdx < StepTotal)
			|-> (sinceRise == EnableCycles + ExpGaps[riseIdx - 1] + 1))
	else
	begin
		timingErrors++;
		$display("Error: LcdEnable rise spacing %h, expected %h",
			$sampled(sinceRise), EnableCycles + ExpGaps[$sampled(riseIdx) - 1] + 1);
	end

	assert property (@(posedge Clock) disable iff (rst)
		(Ready && !prevReady)
			|-> (riseIdx == StepTotal && sinceRise == EnableCycles + ClearGapCycles + 1))
	else
	begin
		timingErrors++;
		$display("Error: Ready rose after write %h, %h cycles from last rise, expected %h",
			$sampled(riseIdx), $sampled(sinceRise), EnableCycles + ClearGapCycles + 1);
	end

	assert property (@(posedge Clock) disable iff (rst) prevReady |-> Ready)
	else
	begin
		timingErrors++;
		$display("Error: Ready = %h, dropped without reset", $sampled(Ready));
	end

	assert property (@(posedge Clock) disable iff (rst) Ready |-> !LcdEnable)
	else
	begin
		timingErrors++;
		$display("Error: LcdEnable = %h while Ready is high", $sampled(LcdEnable));
	end

	// Synchronous reset clears outputs one edge later
	assert property (@(posedge Clock) prevRst |-> (!LcdEnable && !Ready))
	else
	begin
		timingErrors++;
		$display("Error: LcdEnable = %h, Ready = %h after reset",
			$sampled(LcdEnable), $sampled(Ready));
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////

	// 15 bits from a 31-bit LCG
	function automatic int unsigned nextRandom();
		lcgState = (lcgState * 32'd1103515245 + 32'd12345) & 32'h7FFFFFFF;
		return (lcgState >> 16) & 32'h7FFF;
	endfunction

	// Called on a falling edge
	task automatic applyReset(input int cycles);
		rst = 1'b1;
		repeat (cycles) @(negedge Clock);
		rst = 1'b0;
	endtask

	task automatic waitCycles(input int cycles);
		repeat (cycles) @(negedge Clock);
	endtask

	task automatic waitForReady();
		int waited;
		waited = 0;
		while (Ready !== 1'b1 && waited < ReadyTimeout)
		begin
			@(negedge Clock);
			waited++;
		end
		if (Ready !== 1'b1)
		begin
			timeoutErrors++;
			$display("Ready did not rise within %0d cycles of reset release", ReadyTimeout);
		end
	endtask

	////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////

	initial
	begin
		int total;
		int delay;
		int round;
		rst = 1'b1; // Held from time zero
		lcgState = 35;
		applyReset(ResetCycles);
		waitForReady(); // Full run from power-on
		waitCycles(IdleCycles); // No more traffic once Ready
		applyReset(ResetCycles); // Reset while Ready is high
		for (round = 0; round < ResetRounds; round++)
		begin
			delay = PowerOnCycles + 2 + int'(nextRandom() % MidSpan); // Somewhere among the writes
			waitCycles(delay);
			applyReset(1 + int'(nextRandom() % 3));
		end
		waitForReady(); // Restart runs to the end
		waitCycles(IdleCycles);
		total = valueErrors + timingErrors + timeoutErrors;
		$display("Check summary: %0d value errors, %0d timing errors, %0d timeouts",
			valueErrors, timingErrors, timeoutErrors);
		if (total == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	// Last resort if the sequence never ends
	initial
	begin
		repeat (MaxCycles) @(posedge Clock);
		$display("Run did not finish within %0d cycles", MaxCycles);
		$display("Simulation failed");
		$finish;
	end

endmodule
